//--- compile.f
+incdir+include
verilog/converter_pkg.sv
verilog/sine_quadrant_rom.sv
verilog/adc_capture.sv
verilog/panel_ctrl.sv
verilog/wave_gen.sv
verilog/converter_ctrl_top.sv
tb/converter_ctrl_chk.sv
tb/converter_ctrl_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := converter_ctrl_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

# every source in the file list plus the included headers
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/converter_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "converter_params.svh"

module converter_ctrl_tb
   import converter_pkg::*;
();

   localparam int      RESET_CYCLES   = 10;
   localparam int      N_ROWS         = 10;
   localparam int      ROW_CYCLES     = 2;
   localparam int      LFSR_BURST     = 32;
   localparam int      PERIOD         = `CONV_TABLE_LEN;
   localparam int      QTR            = `CONV_QUARTER_LEN;
   localparam int      REC_LEN        = 2 * PERIOD;
   localparam int      HOLD_CYCLES    = 10;
   localparam int      TIMEOUT_CYCLES = RESET_CYCLES + N_ROWS * ROW_CYCLES + LFSR_BURST
                                        + 3 * PERIOD + 200;
   localparam int      MSB            = $bits(sample_t) - 1;
   localparam sample_t MIDSCALE       = 14'h1FFF;
   localparam sample_t FULL_SCALE     = 14'h3FFF;
   localparam sample_t MIRROR_SUM     = 14'h3FFE;

   typedef struct packed {
      logic [3:0] sw;
      sample_t    ada;
      sample_t    adb;
      logic       ora;
      logic       orb;
      sample_t    exp_dac;
      logic       exp_pol;
      logic [7:0] exp_led;
      logic       exp_dfs;
      logic       exp_dcs;
   } row_t;

   // sw, ada, adb, ora, orb, dac a, pol, leds, dfs, dcs
   row_t rows [N_ROWS] = '{
      '{4'b0001, 14'h0000, 14'h0123, 1'b0, 1'b0, 14'h0000, 1'b1, 8'hFF, 1'b0, 1'b0},
      '{4'b0000, 14'h2000, 14'h3A5C, 1'b0, 1'b0, 14'h2000, 1'b0, 8'hFE, 1'b0, 1'b0},
      '{4'b0000, 14'h1FFF, 14'h0FFF, 1'b1, 1'b0, 14'h1FFF, 1'b1, 8'hF6, 1'b0, 1'b0},
      '{4'b0000, 14'h3FFF, 14'h2000, 1'b0, 1'b1, 14'h3FFF, 1'b0, 8'hEE, 1'b0, 1'b0},
      '{4'b0000, 14'h0001, 14'h1234, 1'b1, 1'b1, 14'h0001, 1'b1, 8'hE6, 1'b0, 1'b0},
      '{4'b0100, 14'h2ABC, 14'h1555, 1'b0, 1'b0, 14'h2ABC, 1'b0, 8'hFE, 1'b1, 1'b0},
      '{4'b1000, 14'h1555, 14'h2ABC, 1'b1, 1'b1, 14'h1555, 1'b1, 8'hE6, 1'b0, 1'b1},
      '{4'b1101, 14'h3000, 14'h0F0F, 1'b1, 1'b1, 14'h3000, 1'b0, 8'hFF, 1'b1, 1'b1},
      '{4'b1100, 14'h0FFF, 14'h3C3C, 1'b0, 1'b1, 14'h0FFF, 1'b1, 8'hEE, 1'b1, 1'b1},
      '{4'b0001, 14'h2001, 14'h0000, 1'b1, 1'b0, 14'h2001, 1'b0, 8'hFF, 1'b0, 1'b0}
   };

   logic       ADA_DCO;
   logic       i_rst;
   sample_t    i_ada_data;
   sample_t    i_adb_data;
   logic       i_ada_or;
   logic       i_adb_or;
   logic [3:0] i_sw;
   sample_t    o_dac_a;
   sample_t    o_dac_b;
   sample_t    o_test_cos;
   logic       o_pol_a;
   logic [7:0] o_led;
   logic       o_ad_dfs;
   logic       o_ad_dcs;
   logic       o_ada_oe;
   logic       o_adb_oe;
   logic       o_ada_cs;
   logic       o_adb_cs;

   int          sample_errs = 0;
   int          bit_errs    = 0;
   int          led_errs    = 0;
   int          other_errs  = 0;
   int          cycle_count = 0;
   logic [31:0] lfsr_state  = 32'd76664;
   sample_t     sin_rec [REC_LEN];
   sample_t     cos_rec [REC_LEN];
   sample_t     sin_ref [REC_LEN];

   converter_ctrl_top dut_i (
      .ADA_DCO    (ADA_DCO),
      .i_rst      (i_rst),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .i_ada_or   (i_ada_or),
      .i_adb_or   (i_adb_or),
      .i_sw       (i_sw),
      .o_dac_a    (o_dac_a),
      .o_dac_b    (o_dac_b),
      .o_test_cos (o_test_cos),
      .o_pol_a    (o_pol_a),
      .o_led      (o_led),
      .o_ad_dfs   (o_ad_dfs),
      .o_ad_dcs   (o_ad_dcs),
      .o_ada_oe   (o_ada_oe),
      .o_adb_oe   (o_adb_oe),
      .o_ada_cs   (o_ada_cs),
      .o_adb_cs   (o_adb_cs)
   );

   // 40 ns period
   always #20 ADA_DCO = ~ADA_DCO;

   always @(posedge ADA_DCO) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, test sequence did not finish", cycle_count);
         print_counts();
         $display("Done: errors found");
         $finish;
      end
   end

   // ======================================
   // helpers
   // ======================================

   task automatic next_cycle();
      @(posedge ADA_DCO);
      #2;
   endtask

   task automatic print_counts();
      $display("errors: sample %0d, bit %0d, led %0d, other %0d",
               sample_errs, bit_errs, led_errs, other_errs);
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp) begin
         sample_errs++;
         $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         bit_errs++;
         $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         led_errs++;
         $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   // galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // one lfsr step per sample bit
   function automatic sample_t take_sample();
      sample_t v;
      v = '0;
      for (int b = 0; b <= MSB; b++) begin
         v = {v[MSB-1:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   task automatic record_wave(input int count);
      for (int k = 0; k < count; k++) begin
         next_cycle();
         sin_rec[k] = o_dac_b;
         cos_rec[k] = o_test_cos;
      end
   endtask

   function automatic int find_peak(input int count);
      for (int k = 0; k < count; k++) begin
         if (sin_rec[k] == FULL_SCALE) begin
            return k;
         end
      end
      return -1;
   endfunction

   // ======================================
   // waveform relations
   // ======================================

   task automatic check_wave(input int peak);
      int      base;
      sample_t sum;
      base = peak - QTR;
      if (peak < 0 || base < 0) begin
         other_errs++;
         $display("no full-scale sine sample with a phase 0 sample before it");
         return;
      end
      for (int i = base; i + PERIOD < REC_LEN; i++) begin
         check_sample("o_dac_b period", sin_rec[i + PERIOD], sin_rec[i]);
      end
      // cosine leads by a quarter
      for (int i = base; i + QTR < REC_LEN; i++) begin
         check_sample("o_test_cos", cos_rec[i], sin_rec[i + QTR]);
      end
      // half period apart mirrors about midscale, in sample width arithmetic
      for (int i = base; i + 2 * QTR < REC_LEN; i++) begin
         sum = sin_rec[i] + sin_rec[i + 2 * QTR];
         check_sample("o_dac_b mirror sum", sum, MIRROR_SUM);
      end
      for (int k = 0; k < QTR; k++) begin
         if (!(sin_rec[base + k + 1] > sin_rec[base + k])) begin
            other_errs++;
            $display("sine does not rise between phase %0d and %0d", k, k + 1);
         end
      end
      check_sample("o_dac_b phase 0", sin_rec[base], MIDSCALE);
      check_sample("o_dac_b phase 100", sin_rec[base + 2 * QTR], MIDSCALE);
      // quarter peak mirrored about midscale, wrapped to the sample width
      check_sample("o_dac_b phase 150", sin_rec[base + 3 * QTR],
                   sample_t'(MIRROR_SUM - FULL_SCALE));
   endtask

   // ======================================
   // test sequence
   // ======================================

   initial begin
      sample_t filler;
      int      first_peak;
      int      peak;
      ADA_DCO    = 1'b0;
      i_rst      = 1'b1;
      i_sw       = 4'b0001;
      i_ada_data = '0;
      i_adb_data = '0;
      i_ada_or   = 1'b0;
      i_adb_or   = 1'b0;
      repeat (RESET_CYCLES) @(posedge ADA_DCO);
      #2;
      i_rst = 1'b0;

      // reset state, converter held off
      for (int n = 0; n < 4; n++) begin
         check_led("o_led", o_led, 8'hFF);
         check_sample("o_dac_a", o_dac_a, 14'h0000);
         check_sample("o_dac_b", o_dac_b, MIDSCALE);
         check_sample("o_test_cos", o_test_cos, FULL_SCALE);
         check_bit("o_ada_oe", o_ada_oe, 1'b0);
         check_bit("o_adb_oe", o_adb_oe, 1'b0);
         check_bit("o_ada_cs", o_ada_cs, 1'b1);
         check_bit("o_adb_cs", o_adb_cs, 1'b1);
         next_cycle();
      end

      // table rows, second cycle carries an lfsr sample
      for (int r = 0; r < N_ROWS; r++) begin
         i_sw       = rows[r].sw;
         i_ada_data = rows[r].ada;
         i_adb_data = rows[r].adb;
         i_ada_or   = rows[r].ora;
         i_adb_or   = rows[r].orb;
         next_cycle();
         check_sample("o_dac_a", o_dac_a, rows[r].exp_dac);
         check_bit("o_pol_a", o_pol_a, rows[r].exp_pol);
         filler     = take_sample();
         i_ada_data = filler;
         next_cycle();
         check_sample("o_dac_a", o_dac_a, filler);
         check_bit("o_pol_a", o_pol_a, ~filler[MSB]);
         check_led("o_led", o_led, rows[r].exp_led);
         check_bit("o_ad_dfs", o_ad_dfs, rows[r].exp_dfs);
         check_bit("o_ad_dcs", o_ad_dcs, rows[r].exp_dcs);
      end

      // back to back random samples
      filler     = take_sample();
      i_ada_data = filler;
      i_adb_data = take_sample();
      for (int n = 0; n < LFSR_BURST; n++) begin
         next_cycle();
         check_sample("o_dac_a", o_dac_a, filler);
         check_bit("o_pol_a", o_pol_a, ~filler[MSB]);
         filler     = take_sample();
         i_ada_data = filler;
         i_adb_data = take_sample();
      end

      // enable and capture two periods
      i_sw = 4'b0000;
      record_wave(REC_LEN);
      first_peak = find_peak(REC_LEN);
      check_wave(first_peak);
      sin_ref = sin_rec;

      // drop the enable partway into a period
      repeat (60) next_cycle();
      i_sw = 4'b0001;
      repeat (`CONV_SYNC_STAGES + 2) next_cycle();
      for (int n = 0; n < HOLD_CYCLES; n++) begin
         check_sample("o_dac_b", o_dac_b, MIDSCALE);
         check_sample("o_test_cos", o_test_cos, FULL_SCALE);
         next_cycle();
      end

      // restart must line up with the first run from phase 0
      i_sw = 4'b0000;
      record_wave(PERIOD);
      peak = find_peak(PERIOD);
      if (peak != first_peak) begin
         other_errs++;
         $display("restart peak at sample %0d, first run had it at %0d", peak, first_peak);
      end
      for (int k = 0; k < PERIOD; k++) begin
         check_sample("o_dac_b restart", sin_rec[k], sin_ref[k]);
      end

      print_counts();
      if (sample_errs + bit_errs + led_errs + other_errs == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/converter_ctrl_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "converter_params.svh"

module converter_ctrl_chk
   import converter_pkg::*;
#(
   parameter bit PHASE_CHECKS = 1'b1,
   parameter bit LED_CHECKS   = 1'b1
)
(
   input wire         ADA_DCO,
   input wire         i_rst,
   input wire phase_t i_phase,
   input wire         i_enable,
   input wire [7:0]   i_led
);

   // ======================================
   // generator and panel properties
   // ======================================

   generate
      if (PHASE_CHECKS) begin : g_phase
         // phase stays inside one table period
         phase_range_a: assert property (@(posedge ADA_DCO) disable iff (i_rst)
            i_phase <= phase_t'(`CONV_TABLE_LEN - 1))
            else $error("generator phase %0d beyond the table end", i_phase);

         // phase parked at 0 while disabled
         phase_hold_a: assert property (@(posedge ADA_DCO) disable iff (i_rst)
            !i_enable |=> (i_phase == '0))
            else $error("generator phase moved while disabled");
      end

      if (LED_CHECKS) begin : g_led
         // leds dark right out of reset
         led_reset_a: assert property (@(posedge ADA_DCO)
            i_rst |=> (i_led == 8'hFF))
            else $error("status leds lit in the cycle after reset");
      end
   endgenerate

endmodule

bind wave_gen converter_ctrl_chk #(.LED_CHECKS(1'b0)) u_wave_chk (
   .ADA_DCO  (ADA_DCO),
   .i_rst    (i_rst),
   .i_phase  (phase),
   .i_enable (i_enable),
   .i_led    (8'hFF)
);

bind panel_ctrl converter_ctrl_chk #(.PHASE_CHECKS(1'b0)) u_panel_chk (
   .ADA_DCO  (ADA_DCO),
   .i_rst    (i_rst),
   .i_phase  (8'd0),
   .i_enable (o_enable),
   .i_led    (o_led)
);

`default_nettype wire

//--- verilog/converter_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module converter_ctrl_top
   import converter_pkg::*;
(
   // clock and reset
   input  wire        ADA_DCO,
   input  wire        i_rst,
   // adc data and out-of-range flags
   input  wire        sample_t i_ada_data,
   input  wire        sample_t i_adb_data,
   input  wire        i_ada_or,
   input  wire        i_adb_or,
   // board switches
   input  wire  [3:0] i_sw,
   // dac outputs and bridge test pin
   output sample_t    o_dac_a,
   output sample_t    o_dac_b,
   output sample_t    o_test_cos,
   output logic       o_pol_a,
   // board leds
   output logic [7:0] o_led,
   // adc configuration and control pins
   output logic       o_ad_dfs,
   output logic       o_ad_dcs,
   output logic       o_ada_oe,
   output logic       o_adb_oe,
   output logic       o_ada_cs,
   output logic       o_adb_cs
);

   sample_t ch_a;
   logic    or_a;
   logic    or_b;
   logic    enable;

   // ======================================
   // adc control pins
   // ======================================

   // outputs always on, spi chip selects held off
   assign o_ada_oe = 1'b0;
   assign o_adb_oe = 1'b0;
   assign o_ada_cs = 1'b1;
   assign o_adb_cs = 1'b1;

   // ======================================
   // blocks
   // ======================================

   adc_capture u_adc_capture (
      .ADA_DCO    (ADA_DCO),
      .i_rst      (i_rst),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .i_ada_or   (i_ada_or),
      .i_adb_or   (i_adb_or),
      .o_ch_a     (ch_a),
      .o_ch_b     (),
      .o_or_a     (or_a),
      .o_or_b     (or_b),
      .o_pol_a    (o_pol_a)
   );

   panel_ctrl u_panel_ctrl (
      .ADA_DCO  (ADA_DCO),
      .i_rst    (i_rst),
      .i_sw     (i_sw),
      .i_or_a   (or_a),
      .i_or_b   (or_b),
      .o_enable (enable),
      .o_dfs    (o_ad_dfs),
      .o_dcs    (o_ad_dcs),
      .o_led    (o_led)
   );

   // sine to dac b, cosine to the bridge test pin
   wave_gen u_wave_gen (
      .ADA_DCO  (ADA_DCO),
      .i_rst    (i_rst),
      .i_enable (enable),
      .o_sine   (o_dac_b),
      .o_cosine (o_test_cos)
   );

   // live channel a copy to dac a
   assign o_dac_a = ch_a;

endmodule

`default_nettype wire

//--- verilog/wave_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "converter_params.svh"

module wave_gen
   import converter_pkg::*;
(
   input  wire     ADA_DCO,
   input  wire     i_rst,
   input  wire     i_enable,
   output sample_t o_sine,
   output sample_t o_cosine
);

   localparam phase_t  QTR       = phase_t'(`CONV_QUARTER_LEN);
   localparam phase_t  HALF      = phase_t'(2 * `CONV_QUARTER_LEN);
   localparam phase_t  TQTR      = phase_t'(3 * `CONV_QUARTER_LEN);
   localparam phase_t  FULL      = phase_t'(`CONV_TABLE_LEN);
   localparam phase_t  LAST      = phase_t'(`CONV_TABLE_LEN - 1);
   localparam sample_t MID       = sample_t'((1 << (`CONV_SAMPLE_W - 1)) - 1);
   localparam sample_t TWICE_MID = sample_t'((1 << `CONV_SAMPLE_W) - 2);
   localparam sample_t PEAK      = '1;

   phase_t       phase;
   phase_t       cos_phase;
   quarter_idx_t sin_addr;
   quarter_idx_t cos_addr;
   sample_t      sin_q;
   sample_t      cos_q;

   // fold a full period phase onto the quarter rom address
   function automatic quarter_idx_t quad_addr(input phase_t p);
      phase_t a;
      if (p <= QTR) a = p;
      else if (p <= HALF) a = HALF - p;
      else if (p <= TQTR) a = p - HALF;
      else a = FULL - p;
      return quarter_idx_t'(a);
   endfunction

   // ======================================
   // phase counter
   // ======================================

   // parked at phase 0 while disabled
   always_ff @(posedge ADA_DCO) begin
      if (i_rst || !i_enable) begin
         phase <= '0;
      end else if (phase == LAST) begin
         phase <= '0;
      end else begin
         phase <= phase + 8'd1;
      end
   end

   // cosine leads by a quarter period
   assign cos_phase = (phase >= TQTR) ? (phase - TQTR) : (phase + QTR);

   assign sin_addr = quad_addr(phase);
   assign cos_addr = quad_addr(cos_phase);

   sine_quadrant_rom u_rom_sin (
      .i_addr (sin_addr),
      .o_amp  (sin_q)
   );

   sine_quadrant_rom u_rom_cos (
      .i_addr (cos_addr),
      .o_amp  (cos_q)
   );

   // ======================================
   // output registers
   // ======================================

   // second half mirrored about midscale
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         o_sine   <= MID;
         o_cosine <= PEAK;
      end else begin
         o_sine   <= (phase > HALF) ? (TWICE_MID - sin_q) : sin_q;
         o_cosine <= (cos_phase > HALF) ? (TWICE_MID - cos_q) : cos_q;
      end
   end

endmodule

`default_nettype wire

//--- verilog/panel_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "converter_params.svh"

module panel_ctrl
   import converter_pkg::*;
(
   input  wire        ADA_DCO,
   input  wire        i_rst,
   input  wire  [3:0] i_sw,
   input  wire        i_or_a,
   input  wire        i_or_b,
   output logic       o_enable,
   output logic       o_dfs,
   output logic       o_dcs,
   output logic [7:0] o_led
);

   logic [`CONV_SYNC_STAGES-1:0][3:0] sw_sync;
   logic [3:0]                        sw_q;

   // ======================================
   // switch synchroniser
   // ======================================

   // all ones at reset keeps the converter off
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         sw_sync <= '1;
      end else begin
         sw_sync[0] <= i_sw;
         for (int i = 1; i < `CONV_SYNC_STAGES; i++) begin
            sw_sync[i] <= sw_sync[i-1];
         end
      end
   end

   assign sw_q = sw_sync[`CONV_SYNC_STAGES-1];

   // switch 0 is active low
   assign o_enable = ~sw_q[0];
   // data format and duty cycle stabiliser selects
   assign o_dfs = sw_q[2];
   assign o_dcs = sw_q[3];

   // status leds, low means lit
   assign o_led[0]   = ~o_enable;
   assign o_led[2:1] = 2'b11;
   assign o_led[3]   = ~(o_enable & i_or_a);
   assign o_led[4]   = ~(o_enable & i_or_b);
   assign o_led[7:5] = 3'b111;

endmodule

`default_nettype wire

//--- verilog/adc_capture.sv
`timescale 1ns/100ps
`default_nettype none

module adc_capture
   import converter_pkg::*;
(
   input  wire     ADA_DCO,
   input  wire     i_rst,
   input  wire     sample_t i_ada_data,
   input  wire     sample_t i_adb_data,
   input  wire     i_ada_or,
   input  wire     i_adb_or,
   output sample_t o_ch_a,
   output sample_t o_ch_b,
   output logic    o_or_a,
   output logic    o_or_b,
   output logic    o_pol_a
);

   // ======================================
   // input registers
   // ======================================

   // both channels sampled on the channel a data clock
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         o_ch_a <= '0;
         o_ch_b <= '0;
         o_or_a <= 1'b0;
         o_or_b <= 1'b0;
         // zero sample sits below midscale
         o_pol_a <= 1'b1;
      end else begin
         o_ch_a <= i_ada_data;
         o_ch_b <= i_adb_data;
         o_or_a <= i_ada_or;
         o_or_b <= i_adb_or;
         // zero crossing of channel a, top bit clear means lower half
         o_pol_a <= ~i_ada_data[$bits(sample_t)-1];
      end
   end

endmodule

`default_nettype wire

//--- verilog/sine_quadrant_rom.sv
`timescale 1ns/100ps
`default_nettype none

module sine_quadrant_rom
   import converter_pkg::*;
(
   input  wire     quarter_idx_t i_addr,
   output sample_t o_amp
);

   // ======================================
   // first quarter of the test sine
   // ======================================

   // rises from midscale at 0 to full scale at 50
   always_comb begin
      case (i_addr)
         6'd0:    o_amp = 14'h1FFF;
         6'd1:    o_amp = 14'h2100;
         6'd2:    o_amp = 14'h2201;
         6'd3:    o_amp = 14'h2302;
         6'd4:    o_amp = 14'h2402;
         6'd5:    o_amp = 14'h2500;
         6'd6:    o_amp = 14'h25FE;
         6'd7:    o_amp = 14'h26FA;
         6'd8:    o_amp = 14'h27F4;
         6'd9:    o_amp = 14'h28EC;
         6'd10:   o_amp = 14'h29E2;
         6'd11:   o_amp = 14'h2AD6;
         6'd12:   o_amp = 14'h2BC6;
         6'd13:   o_amp = 14'h2CB4;
         6'd14:   o_amp = 14'h2D9F;
         6'd15:   o_amp = 14'h2E86;
         6'd16:   o_amp = 14'h2F69;
         6'd17:   o_amp = 14'h3049;
         6'd18:   o_amp = 14'h3124;
         6'd19:   o_amp = 14'h31FB;
         6'd20:   o_amp = 14'h32CE;
         6'd21:   o_amp = 14'h339C;
         6'd22:   o_amp = 14'h3464;
         6'd23:   o_amp = 14'h3528;
         6'd24:   o_amp = 14'h35E6;
         // 45 degrees
         6'd25:   o_amp = 14'h369F;
         6'd26:   o_amp = 14'h3752;
         6'd27:   o_amp = 14'h3800;
         6'd28:   o_amp = 14'h38A7;
         6'd29:   o_amp = 14'h3948;
         6'd30:   o_amp = 14'h39E2;
         6'd31:   o_amp = 14'h3A76;
         6'd32:   o_amp = 14'h3B03;
         6'd33:   o_amp = 14'h3B8A;
         6'd34:   o_amp = 14'h3C09;
         6'd35:   o_amp = 14'h3C82;
         6'd36:   o_amp = 14'h3CF3;
         6'd37:   o_amp = 14'h3D5D;
         6'd38:   o_amp = 14'h3DBF;
         6'd39:   o_amp = 14'h3E1A;
         6'd40:   o_amp = 14'h3E6E;
         6'd41:   o_amp = 14'h3EB9;
         6'd42:   o_amp = 14'h3EFD;
         6'd43:   o_amp = 14'h3F39;
         6'd44:   o_amp = 14'h3F6D;
         6'd45:   o_amp = 14'h3F9A;
         6'd46:   o_amp = 14'h3FBE;
         6'd47:   o_amp = 14'h3FDA;
         6'd48:   o_amp = 14'h3FEE;
         6'd49:   o_amp = 14'h3FFA;
         6'd50:   o_amp = 14'h3FFF;
         // out of range addresses clamp to the peak
         default: o_amp = 14'h3FFF;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/converter_pkg.sv
`default_nettype none

`include "converter_params.svh"

package converter_pkg;

   // offset binary sample, midscale is 1fff
   typedef logic [`CONV_SAMPLE_W-1:0] sample_t;

   // generator phase, 0 to 199
   typedef logic [7:0] phase_t;

   // quarter-wave rom address, 0 to 50
   typedef logic [5:0] quarter_idx_t;

endpackage

`default_nettype wire

//--- include/converter_params.svh
`ifndef CONVERTER_PARAMS_SVH
`define CONVERTER_PARAMS_SVH

// ======================================
// converter front end sizes
// ======================================

// adc and dac sample width in bits
`define CONV_SAMPLE_W     14

// samples per test waveform period
`define CONV_TABLE_LEN    200

// samples per quarter period, quarter rom holds one more
`define CONV_QUARTER_LEN  50

// flops in the panel switch synchroniser
`define CONV_SYNC_STAGES  2

`endif
